// ==== vlog.f ====
+incdir+hw
hw/rv_exec_pkg.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/alu.sv
hw/exec_top.sv
testbench/exec_checker.sv
testbench/exec_tb.sv

// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_exec_pkg.sv
      - hw/instr_decoder.sv
      - hw/register_file.sv
      - hw/alu.sv
      - hw/exec_top.sv
      - testbench/exec_checker.sv
      - testbench/exec_tb.sv

// ==== testbench/exec_tb.sv ====
`timescale 1ns/1ns
`include "rv_exec_defines.svh"

module exec_tb;

    // Instructions per test in run order
    localparam int INSTR_COUNT = 32 + 186 + 72 + 36 + 35 + 35;
    localparam int TIMEOUT_NS  = (INSTR_COUNT + 12) * 10 + 1000;
    // R-type ops as {alt, funct3} with ADD in the low nibble
    localparam logic [39:0] R_OPS = {4'b0111, 4'b0110, 4'b1101, 4'b0101, 4'b0100,
                                     4'b0011, 4'b0010, 4'b0001, 4'b1000, 4'b0000};

    logic             clk;
    logic             rstN;
    logic [`XLEN-1:0] instr;
    logic             instrValid;
    logic [`XLEN-1:0] result;
    logic             flag;
    logic             illegal;
    logic [`XLEN-1:0] model [`NREGS]; // Shadow register file
    logic [31:0]      lfsrState;
    int               errorCount;
    int               checkCount;

    exec_top UUT (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .result     (result),
        .flag       (flag),
        .illegal    (illegal)
    );

    always #5 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState); // One step per bit
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] opc, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    // Architectural result of OP and OP-IMM
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Drive on the falling edge and sample well before the rising one
    task automatic issueInstr(input logic [31:0] ins, input logic valid);
        @(negedge clk);
        instr      = ins;
        instrValid = valid;
        #2;
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    // ADD x0, idx, x0 without valid shows the register on result
    task automatic readBack(input logic [4:0] idx);
        issueInstr(rType(7'h00, 5'd0, idx, 3'b000, 5'd0), 1'b0);
        checkValue($sformatf("x%0d read back", idx), result, model[idx]);
    endtask

    task automatic compareAllRegs();
        for (int r = 0; r < `NREGS; r++)
            readBack(5'(r));
    endtask

    task automatic runOp(input string what, input logic [31:0] ins, input logic [31:0] exp);
        logic [4:0] rd;
        rd = ins[11:7];
        issueInstr(ins, 1'b1);
        checkValue(what, result, exp);
        checkValue({what, " zero flag"}, {31'd0, flag}, {31'd0, exp == 32'd0});
        if (rd != 5'd0)
            model[rd] = exp;
        readBack(rd);
    endtask

    task automatic loadReg(input logic [4:0] idx, input logic [11:0] imm);
        runOp("ADDI load", iType(`OPC_OPIMM, imm, 5'd0, 3'b000, idx), sext12(imm));
    endtask

    // --------------------
    // Directed tests
    // --------------------

    task automatic resetReadsZero();
        for (int r = 0; r < `NREGS; r++) begin
            issueInstr(rType(7'h00, 5'd0, 5'(r), 3'b000, 5'(r)), 1'b0);
            checkValue($sformatf("x%0d after reset", r), result, 32'd0);
        end
    endtask

    task automatic regRegOps();
        logic [11:0] v;
        logic [3:0]  code;
        for (int r = 1; r <= 3; r++) begin
            v = 12'(randBits(12));
            if (r == 1)
                v[11] = 1'b1; // x1 negative and x2 positive
            if (r == 2)
                v[11] = 1'b0;
            loadReg(5'(r), v);
        end
        for (int a = 1; a <= 3; a++) begin
            for (int b = 1; b <= 3; b++) begin
                for (int op = 0; op < 10; op++) begin
                    code = R_OPS[op*4 +: 4];
                    runOp($sformatf("R-type %b x%0d,x%0d", code, a, b),
                          rType(code[3] ? 7'b0100000 : 7'b0000000, 5'(b), 5'(a),
                                code[2:0], 5'(10 + op)),
                          aluRef(code[2:0], code[3], model[a], model[b]));
                end
            end
        end
    endtask

    task automatic regImmOps();
        logic [11:0] imm;
        logic [11:0] useImm;
        logic [2:0]  f3;
        logic        alt;
        for (int s = 1; s <= 2; s++) begin
            for (int k = 0; k < 2; k++) begin
                imm = (k == 0) ? 12'(randBits(12)) : 12'hFFF; // Random then minus one
                for (int op = 0; op < 9; op++) begin
                    f3     = (op == 8) ? 3'b101 : 3'(op); // Last one is SRAI
                    alt    = (op == 8);
                    useImm = imm;
                    if (f3 == 3'b001 || f3 == 3'b101)
                        useImm = {1'b0, alt, 5'b00000, imm[4:0]};
                    runOp($sformatf("I-type f3=%0d x%0d imm=%h", f3, s, useImm),
                          iType(`OPC_OPIMM, useImm, 5'(s), f3, 5'(20 + op)),
                          aluRef(f3, alt, model[s], sext12(useImm)));
                end
            end
        end
    endtask

    task automatic branchConditions();
        int a;
        int b;
        loadReg(5'd25, 12'd5);
        loadReg(5'd26, 12'h7F0);
        loadReg(5'd27, 12'hFFD); // Minus three is the largest unsigned
        for (int p = 0; p < 5; p++) begin
            a = (p == 2 || p == 4) ? ((p == 2) ? 26 : 27) : 25;
            b = (p == 0) ? 25 : ((p == 1) ? 26 : ((p == 3) ? 27 : 25));
            for (int j = 0; j < 8; j++) begin
                if (j != 2 && j != 3) begin
                    issueInstr(bType(13'd16, 5'(b), 5'(a), 3'(j)), 1'b1);
                    checkValue($sformatf("branch f3=%0d x%0d,x%0d flag", j, a, b),
                               {31'd0, flag}, {31'd0, branchRef(3'(j), model[a], model[b])});
                end
            end
        end
    endtask

    task automatic memAddrAndIllegal();
        logic [11:0] imm;
        imm = 12'(randBits(12));
        issueInstr(iType(`OPC_LOAD, imm, 5'd1, 3'b010, 5'd9), 1'b1);
        checkValue("load address", result, model[1] + sext12(imm));
        checkValue("load illegal", {31'd0, illegal}, 32'd0);
        imm = 12'(randBits(12));
        issueInstr(sType(imm, 5'd2, 5'd3, 3'b010), 1'b1);
        checkValue("store address", result, model[3] + sext12(imm));
        // Undefined opcode aimed at a live register
        issueInstr({imm, 5'd1, 3'b000, 5'd10, 7'b1111111}, 1'b1);
        checkValue("undefined opcode illegal", {31'd0, illegal}, 32'd1);
        compareAllRegs();
    endtask

    task automatic discardedWrites();
        issueInstr(iType(`OPC_OPIMM, 12'h123, 5'd0, 3'b000, 5'd0), 1'b1);
        checkValue("ADDI to x0 result", result, 32'h123);
        issueInstr(iType(`OPC_OPIMM, 12'(randBits(12)), 5'd0, 3'b000, 5'd4), 1'b0);
        issueInstr(rType(7'h00, 5'd1, 5'd2, 3'b000, 5'd5), 1'b0);
        compareAllRegs();
    endtask

    // --------------------
    // Run and watchdog
    // --------------------

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        lfsrState  = 32'd90;
        errorCount = 0;
        checkCount = 0;
        for (int r = 0; r < `NREGS; r++)
            model[r] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        resetReadsZero();
        regRegOps();
        regImmOps();
        branchConditions();
        memAddrAndIllegal();
        discardedWrites();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== testbench/exec_checker.sv ====
`timescale 1ns/1ns
`include "rv_exec_defines.svh"

module exec_checker (
    input logic               clk,
    input logic               rstN,
    input logic               instrValid,
    input logic               illegal,
    input logic               wrEn,
    input logic [`REGIDX-1:0] rs1,
    input logic [`REGIDX-1:0] rs2,
    input logic [`XLEN-1:0]   rs1Data,
    input logic [`XLEN-1:0]   rs2Data
);

    // --------------------
    // Write enable
    // --------------------

    wrOnIllegal: assert property (@(posedge clk) disable iff (!rstN) illegal |-> !wrEn)
        else $error("register write enabled on an illegal instruction");

    wrWithoutValid: assert property (@(posedge clk) disable iff (!rstN) !instrValid |-> !wrEn)
        else $error("register write enabled while instrValid is low");

    // --------------------
    // Hard-wired x0
    // --------------------

    x0ReadPort1: assert property (@(posedge clk) disable iff (!rstN)
        (rs1 == '0) |-> (rs1Data == '0))
        else $error("x0 read on port 1 is not zero");

    x0ReadPort2: assert property (@(posedge clk) disable iff (!rstN)
        (rs2 == '0) |-> (rs2Data == '0))
        else $error("x0 read on port 2 is not zero");

endmodule

bind exec_top exec_checker uChecker (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .illegal    (illegal),
    .wrEn       (wrEn),
    .rs1        (dec.rs1),
    .rs2        (dec.rs2),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data)
);

// ==== hw/exec_top.sv ====
`timescale 1ns/1ns
`include "rv_exec_defines.svh"

module exec_top (
    input  logic             clk,
    input  logic             rstN,
    input  logic [`XLEN-1:0] instr,
    input  logic             instrValid,
    output logic [`XLEN-1:0] result,
    output logic             flag,
    output logic             illegal
);

    rv_exec_pkg::decodeT dec;
    rv_exec_pkg::aluOutT aluOut;
    logic [`XLEN-1:0]    rs1Data;
    logic [`XLEN-1:0]    rs2Data;
    logic                wrEn;

    // --------------------
    // Decode
    // --------------------

    instr_decoder uDecoder (
        .instr (instr),
        .dec   (dec)
    );

    // Only valid OP and OP-IMM instructions reach the write port
    assign wrEn = instrValid & dec.regWrite;

    // --------------------
    // Register file
    // --------------------

    register_file uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .rd      (dec.rd),
        .wrEn    (wrEn),
        .wrData  (aluOut.result) // Write-back on the next edge
    );

    // --------------------
    // Execute
    // --------------------

    alu uAlu (
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .dec     (dec),
        .out     (aluOut)
    );

    assign result  = aluOut.result;
    assign flag    = aluOut.flag;
    assign illegal = dec.illegal;

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ns
`include "rv_exec_defines.svh"

module alu (
    input  logic [`XLEN-1:0]    rs1Data,
    input  logic [`XLEN-1:0]    rs2Data,
    input  rv_exec_pkg::decodeT dec,
    output rv_exec_pkg::aluOutT out
);

    // funct3 codes
    localparam logic [2:0] F3_ADD  = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // Logical or arithmetic by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA

    rv_exec_pkg::aluCtrlE ctrl;
    logic [`XLEN-1:0]     op1;
    logic [`XLEN-1:0]     op2;
    logic                 signExt;
    logic [`XLEN:0]       diff; // One extra bit keeps the compare sign exact

    assign op1 = rs1Data;
    assign op2 = dec.aluSrc ? dec.imm : rs2Data;

    // --------------------
    // Control decode
    // --------------------

    always_comb begin
        ctrl = rv_exec_pkg::NONE;
        case (dec.aluClass)
            rv_exec_pkg::MEM: ctrl = rv_exec_pkg::ADD; // Address add
            rv_exec_pkg::BRANCH: begin
                if (dec.funct3 == F3_BLTU || dec.funct3 == F3_BGEU)
                    ctrl = rv_exec_pkg::SUBU;
                else
                    ctrl = rv_exec_pkg::SUB;
            end
            rv_exec_pkg::REG: begin
                case ({dec.funct3, dec.funct7})
                    {F3_ADD,  F7_BASE}: ctrl = rv_exec_pkg::ADD;
                    {F3_ADD,  F7_ALT}:  ctrl = rv_exec_pkg::SUB;
                    {F3_SLL,  F7_BASE}: ctrl = rv_exec_pkg::SHL;
                    {F3_SLT,  F7_BASE}: ctrl = rv_exec_pkg::LT;
                    {F3_SLTU, F7_BASE}: ctrl = rv_exec_pkg::LTU;
                    {F3_XOR,  F7_BASE}: ctrl = rv_exec_pkg::XOR;
                    {F3_SR,   F7_BASE}: ctrl = rv_exec_pkg::SHR;
                    {F3_SR,   F7_ALT}:  ctrl = rv_exec_pkg::SHRA;
                    {F3_OR,   F7_BASE}: ctrl = rv_exec_pkg::OR;
                    {F3_AND,  F7_BASE}: ctrl = rv_exec_pkg::AND;
                    default:            ctrl = rv_exec_pkg::NONE;
                endcase
            end
            rv_exec_pkg::IMM: begin
                case (dec.funct3)
                    F3_ADD:  ctrl = rv_exec_pkg::ADD;
                    F3_SLL:  ctrl = rv_exec_pkg::SHL;
                    F3_SLT:  ctrl = rv_exec_pkg::LT;
                    F3_SLTU: ctrl = rv_exec_pkg::LTU;
                    F3_XOR:  ctrl = rv_exec_pkg::XOR;
                    F3_SR:   ctrl = dec.funct7[5] ? rv_exec_pkg::SHRA : rv_exec_pkg::SHR;
                    F3_OR:   ctrl = rv_exec_pkg::OR;
                    F3_AND:  ctrl = rv_exec_pkg::AND;
                    default: ctrl = rv_exec_pkg::NONE;
                endcase
            end
            default: ctrl = rv_exec_pkg::NONE;
        endcase
    end

    // --------------------
    // Datapath
    // --------------------

    // Sign or zero extension decides the meaning of diff[XLEN]
    assign signExt = (ctrl != rv_exec_pkg::SUBU);
    assign diff    = {signExt & op1[`XLEN-1], op1} - {signExt & op2[`XLEN-1], op2};

    always_comb begin
        case (ctrl)
            rv_exec_pkg::SHL:  out.result = op1 << op2[4:0];
            rv_exec_pkg::SHR:  out.result = op1 >> op2[4:0];
            rv_exec_pkg::SHRA: out.result = $signed(op1) >>> op2[4:0];
            rv_exec_pkg::ADD:  out.result = op1 + op2;
            rv_exec_pkg::SUB,
            rv_exec_pkg::SUBU: out.result = diff[`XLEN-1:0];
            rv_exec_pkg::AND:  out.result = op1 & op2;
            rv_exec_pkg::OR:   out.result = op1 | op2;
            rv_exec_pkg::XOR:  out.result = op1 ^ op2;
            rv_exec_pkg::LTU:  out.result = {{(`XLEN-1){1'b0}}, op1 < op2};
            rv_exec_pkg::LT:   out.result = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            default:           out.result = '0; // NONE
        endcase
    end

    // Branch condition, zero result for everything else
    always_comb begin
        out.flag = (out.result == '0);
        if (dec.aluClass == rv_exec_pkg::BRANCH) begin
            case (dec.funct3)
                F3_BEQ:          out.flag = (out.result == '0);
                F3_BNE:          out.flag = (out.result != '0);
                F3_BLT, F3_BLTU: out.flag = diff[`XLEN];  // Negative difference
                F3_BGE, F3_BGEU: out.flag = !diff[`XLEN];
                default:         out.flag = (out.result == '0);
            endcase
        end
    end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ns
`include "rv_exec_defines.svh"

module register_file (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`REGIDX-1:0] rs1,
    input  logic [`REGIDX-1:0] rs2,
    output logic [`XLEN-1:0]   rs1Data,
    output logic [`XLEN-1:0]   rs2Data,
    input  logic [`REGIDX-1:0] rd,
    input  logic               wrEn,
    input  logic [`XLEN-1:0]   wrData
);

    logic [`XLEN-1:0] regs [`NREGS];

    // --------------------
    // Write port
    // --------------------

    // Architectural state, cleared so every register reads zero after reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rd != '0)) begin // x0 writes dropped
            regs[rd] <= wrData;
        end
    end

    // --------------------
    // Read ports
    // --------------------

    // Combinational; new data visible the cycle after the write edge
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

endmodule

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ns
`include "rv_exec_defines.svh"

module instr_decoder (
    input  logic [`XLEN-1:0]    instr,
    output rv_exec_pkg::decodeT dec
);

    logic [6:0]       opcode;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;

    assign opcode = instr[6:0];

    // --------------------
    // Immediate formats
    // --------------------

    // I format, OP-IMM and loads
    assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};

    // S format splits the offset around rd
    assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    // B format, bit 0 always zero
    assign immB = {
        {(`XLEN-13){instr[31]}},
        instr[31],
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };

    // --------------------
    // Field split and control
    // --------------------

    always_comb begin
        // Fixed fields, taken whatever the format
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.rd     = instr[11:7];
        dec.funct3 = instr[14:12];
        dec.funct7 = instr[31:25];

        // Defaults: no write, register operand
        dec.imm      = '0;
        dec.aluClass = rv_exec_pkg::MEM;
        dec.aluSrc   = 1'b0;
        dec.regWrite = 1'b0;
        dec.illegal  = 1'b0;

        case (opcode)
            `OPC_OP: begin
                dec.aluClass = rv_exec_pkg::REG;
                dec.regWrite = 1'b1;
            end
            `OPC_OPIMM: begin
                dec.imm      = immI;
                dec.aluClass = rv_exec_pkg::IMM;
                dec.aluSrc   = 1'b1;
                dec.regWrite = 1'b1;
            end
            `OPC_LOAD: begin
                dec.imm      = immI;
                dec.aluClass = rv_exec_pkg::MEM; // Address only
                dec.aluSrc   = 1'b1;
            end
            `OPC_STORE: begin
                dec.imm      = immS;
                dec.aluClass = rv_exec_pkg::MEM;
                dec.aluSrc   = 1'b1;
            end
            `OPC_BRANCH: begin
                // Compare rs1 against rs2, imm only kept for completeness
                dec.imm      = immB;
                dec.aluClass = rv_exec_pkg::BRANCH;
            end
            default: begin
                dec.illegal = 1'b1; // regWrite stays low
            end
        endcase
    end

endmodule

// ==== hw/rv_exec_pkg.sv ====
`include "rv_exec_defines.svh"

package rv_exec_pkg;

    // --------------------
    // Operation class
    // --------------------

    // Two-bit class the decoder hands to the ALU
    typedef enum logic [1:0] {
        MEM    = 2'b00, // Load/store address add
        BRANCH = 2'b01, // Compare by subtraction
        REG    = 2'b10, // R-type
        IMM    = 2'b11  // I-type
    } aluClassE;

    // --------------------
    // ALU control
    // --------------------

    typedef enum logic [3:0] {
        NONE = 4'd0,  // Result forced to zero
        SHL  = 4'd1,
        SHR  = 4'd2,
        SHRA = 4'd3,  // Arithmetic right shift
        ADD  = 4'd4,
        SUB  = 4'd5,  // Signed compare for branches
        AND  = 4'd6,
        OR   = 4'd7,
        XOR  = 4'd8,
        LTU  = 4'd9,
        LT   = 4'd10,
        SUBU = 4'd11  // Unsigned compare for BLTU, BGEU
    } aluCtrlE;

    // --------------------
    // Decoder output
    // --------------------

    typedef struct packed {
        logic [`REGIDX-1:0] rs1;
        logic [`REGIDX-1:0] rs2;
        logic [`REGIDX-1:0] rd;
        logic [2:0]         funct3;
        logic [6:0]         funct7;
        logic [`XLEN-1:0]   imm;      // Sign-extended, format chosen by opcode
        aluClassE           aluClass;
        logic               aluSrc;   // 1 selects imm as operand 2
        logic               regWrite; // Result goes to rd
        logic               illegal;  // Opcode outside the supported set
    } decodeT;

    // ALU output
    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic             flag; // Branch condition or zero result
    } aluOutT;

endpackage

// ==== hw/rv_exec_defines.svh ====
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// --------------------
// Datapath sizes
// --------------------

`define XLEN    32 // Data and instruction width
`define NREGS   32 // Architectural registers x0..x31
`define REGIDX  5  // Bits of a register index

// --------------------
// Major opcodes, instr[6:0]
// --------------------

// R-type ALU
`define OPC_OP      7'b0110011
// I-type ALU
`define OPC_OPIMM   7'b0010011
`define OPC_LOAD    7'b0000011 // Address only
`define OPC_STORE   7'b0100011 // Address only
// Condition only, no target
`define OPC_BRANCH  7'b1100011

`endif
